//--- run_sim.sh
#!/bin/sh
# Build and run the xHCI register block testbench with Verilator

rm -f sim.log
verilator --binary --timing --assert -f vlog.f --top-module tb_xhci_controller \
    -Mdir obj_dir > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/Vtb_xhci_controller > sim.log 2>&1
cat sim.log

grep -q "tests failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "all tests passed" sim.log || { echo "FAIL: run ended early"; exit 1; }
echo "PASS"

//--- tb_xhci_controller.sv
// xHCI register block testbench
// Runs the operations listed in the case file against the controller
// over its AXI port and checks registers and interrupt outputs

`timescale 1ns/1ps
`default_nettype none
`include "xhci_consts.svh"

module tb_xhci_controller;
    import xhci_reg_pkg::*;

    localparam int HANDSHAKE_LIMIT = 50;
    localparam int POLL_LIMIT      = 400;

    logic        clk_sys = 1'b0;
    logic        rst_n_sys;
    reg_addr_t   awaddr;
    logic        awvalid;
    reg_data_t   wdata;
    logic        wvalid;
    logic        awready;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    reg_addr_t   araddr;
    logic        arvalid;
    logic        arready;
    reg_data_t   rdata;
    logic [1:0]  rresp;
    logic        rlast;
    logic        rvalid;
    logic        rready;
    logic        port_connect;
    logic        port_disconnect;
    logic        port_overcurrent;
    logic        event_intr;
    logic        port_intr;

    // Enqueue index last rung per endpoint
    logic [7:0]  ring_model [`XHCI_NUM_EPS];
    logic [15:0] lfsr_state = 16'd23179;
    logic [31:0] last_mfindex;

    xhci_controller_top DUT (.*);

    always #5 clk_sys = ~clk_sys;

    task automatic stop_with_failure();
        $display("tests failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, expected);
            stop_with_failure();
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic next_random_byte(output logic [7:0] value);
        value = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[6:0], lfsr_state[0]};
        end
    endtask

    function automatic logic in_doorbell_range(input logic [11:0] addr);
        return addr >= `XHCI_DB_BASE && addr < `XHCI_DB_BASE + 12'(4 * `XHCI_NUM_EPS);
    endfunction

    function automatic logic [3:0] doorbell_index(input logic [11:0] addr);
        return 4'((addr - `XHCI_DB_BASE) >> 2);
    endfunction

    // ------------------------------------------------------------------------
    // AXI single-beat accesses, ready and valid sampled on the falling edge
    // ------------------------------------------------------------------------
    task automatic axi_write(input logic [11:0] addr, input logic [31:0] data);
        int waited;
        waited  = 0;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk_sys);
        while (!(awready && wready)) begin
            if (waited == HANDSHAKE_LIMIT) begin
                $display("Write to 0x%03h was never accepted", addr);
                stop_with_failure();
            end
            waited++;
            @(negedge clk_sys);
        end
        @(posedge clk_sys);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        waited  = 0;
        @(negedge clk_sys);
        while (!bvalid) begin
            if (waited == HANDSHAKE_LIMIT) begin
                $display("No write response for 0x%03h", addr);
                stop_with_failure();
            end
            waited++;
            @(negedge clk_sys);
        end
        check_value("bresp", {30'd0, bresp}, {30'd0, `XHCI_RESP_OKAY});
        @(posedge clk_sys);
        #1;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [11:0] addr, output logic [31:0] data);
        int waited;
        waited  = 0;
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk_sys);
        while (!arready) begin
            if (waited == HANDSHAKE_LIMIT) begin
                $display("Read of 0x%03h was never accepted", addr);
                stop_with_failure();
            end
            waited++;
            @(negedge clk_sys);
        end
        @(posedge clk_sys);
        #1;
        arvalid = 1'b0;
        rready  = 1'b1;
        waited  = 0;
        @(negedge clk_sys);
        while (!rvalid) begin
            if (waited == HANDSHAKE_LIMIT) begin
                $display("No read data for 0x%03h", addr);
                stop_with_failure();
            end
            waited++;
            @(negedge clk_sys);
        end
        data = rdata;
        check_value("rresp", {30'd0, rresp}, {30'd0, `XHCI_RESP_OKAY});
        check_value("rlast", {31'd0, rlast}, 32'd1);
        @(posedge clk_sys);
        #1;
        rready = 1'b0;
    endtask

    task automatic poll_doorbell(input logic [11:0] addr, input logic [31:0] expected);
        logic [31:0] got;
        int          polls;
        polls = 0;
        axi_read(addr, got);
        while (got != expected) begin
            if (polls == POLL_LIMIT) begin
                $display("Dequeue pointer at 0x%03h stuck at 0x%02h, waiting for 0x%02h",
                         addr, got, expected);
                stop_with_failure();
            end
            polls++;
            axi_read(addr, got);
        end
    endtask

    task automatic check_mfindex(input logic [31:0] mode);
        logic [31:0] got;
        axi_read(`XHCI_MFINDEX_OFS, got);
        if (mode == 32'd0) begin
            check_value("mfindex", got, last_mfindex);
        end else if (mode == 32'd1) begin
            assert (got > last_mfindex) else begin
                $display("[FAIL] mfindex got 0x%08h not above 0x%08h", got, last_mfindex);
                stop_with_failure();
            end
        end
        last_mfindex = got;
    endtask

    // ------------------------------------------------------------------------
    // Case file
    // ------------------------------------------------------------------------
    task automatic run_cases();
        int          fd;
        int          fields;
        string       line;
        logic [7:0]  op;
        logic [31:0] case_addr;
        logic [31:0] case_value;
        logic [31:0] got;
        logic [7:0]  db_value;
        logic [3:0]  ep;
        fd = $fopen("xhci_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file");
            stop_with_failure();
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%c %h %h", op, case_addr, case_value);
            if (fields != 3) begin
                $display("Malformed case line: %s", line);
                stop_with_failure();
            end
            case (op)
                "W": begin
                    axi_write(case_addr[11:0], case_value);
                    if (in_doorbell_range(case_addr[11:0])) begin
                        ring_model[doorbell_index(case_addr[11:0])] = case_value[7:0];
                    end
                end
                "R": begin
                    axi_read(case_addr[11:0], got);
                    check_value($sformatf("rdata@%03h", case_addr[11:0]), got, case_value);
                end
                "D": poll_doorbell(case_addr[11:0], case_value);
                "L": begin
                    ep = doorbell_index(case_addr[11:0]);
                    next_random_byte(db_value);
                    // Must differ from the current index or the ring never drains
                    if (db_value == ring_model[ep]) begin
                        db_value = db_value + 8'd1;
                    end
                    axi_write(case_addr[11:0], {24'd0, db_value});
                    ring_model[ep] = db_value;
                    poll_doorbell(case_addr[11:0], {24'd0, db_value});
                end
                "P": begin
                    port_connect     = case_value[0];
                    port_disconnect  = case_value[1];
                    port_overcurrent = case_value[2];
                    @(posedge clk_sys);
                    #1;
                end
                "I": begin
                    check_value("event_intr", {31'd0, event_intr}, {31'd0, case_value[0]});
                    check_value("port_intr", {31'd0, port_intr}, {31'd0, case_value[1]});
                end
                "M": check_mfindex(case_value);
                "C": begin
                    repeat (case_value) @(posedge clk_sys);
                    #1;
                end
                default: begin
                    $display("Unknown operation in case line: %s", line);
                    stop_with_failure();
                end
            endcase
        end
        $fclose(fd);
    endtask

    initial begin
        rst_n_sys        = 1'b0;
        awaddr           = '0;
        awvalid          = 1'b0;
        wdata            = '0;
        wvalid           = 1'b0;
        bready           = 1'b0;
        araddr           = '0;
        arvalid          = 1'b0;
        rready           = 1'b0;
        port_connect     = 1'b0;
        port_disconnect  = 1'b0;
        port_overcurrent = 1'b0;
        last_mfindex     = '0;
        for (int i = 0; i < `XHCI_NUM_EPS; i++) begin
            ring_model[i] = '0;
        end
        repeat (5) @(posedge clk_sys);
        #1;
        rst_n_sys = 1'b1;
        @(posedge clk_sys);
        #1;
        run_cases();
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
xhci_reg_pkg.sv
xhci_ring_pkg.sv
xhci_axi_regs.sv
xhci_ring_sched.sv
xhci_mfindex_timer.sv
xhci_intr_ctrl.sv
xhci_controller_top.sv
tb_xhci_controller.sv

//--- xhci_axi_regs.sv
// xHCI register slave
// Single-beat AXI slave for the register window. Holds USBCMD,
// assembles USBSTS, returns capability constants and decodes
// doorbell and PORTSC writes into strobes for the other blocks

`timescale 1ns/1ps
`default_nettype none
`include "xhci_consts.svh"

module xhci_axi_regs (
    input  logic                      clk_sys,
    input  logic                      rst_n_sys,
    input  xhci_reg_pkg::reg_addr_t   awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  xhci_reg_pkg::reg_data_t   wdata,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  xhci_reg_pkg::reg_addr_t   araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output xhci_reg_pkg::reg_data_t   rdata,
    output logic [1:0]                rresp,
    output logic                      rlast,
    output logic                      rvalid,
    input  logic                      rready,
    output logic                      db_wr,
    output xhci_ring_pkg::ep_idx_t    db_ep,
    output xhci_ring_pkg::ring_ptr_t  db_value,
    output logic                      run,
    output logic                      eint_clr,
    output logic                      portsc_clr,
    output xhci_reg_pkg::reg_data_t   portsc_wdata,
    input  logic                      sched_idle,
    output xhci_ring_pkg::ep_idx_t    rd_ep,
    input  xhci_ring_pkg::ring_ptr_t  rd_deq,
    input  xhci_reg_pkg::mfindex_t    mfindex,
    input  xhci_reg_pkg::reg_data_t   portsc_value,
    input  logic                      eint_pending
);
    import xhci_reg_pkg::*;

    logic      wr_accept;
    logic      rd_accept;
    logic      wr_cmd;
    reg_data_t rd_word;

    function automatic logic is_doorbell(input reg_addr_t addr);
        return (addr & `XHCI_DB_MASK) == `XHCI_DB_BASE;
    endfunction

    // ---------------------------------------------------------------------------
    // Handshake
    // ---------------------------------------------------------------------------
    assign wr_accept = awvalid && wvalid && !bvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;
    assign rd_accept = arvalid && !rvalid;
    assign arready   = rd_accept;

    assign bresp = `XHCI_RESP_OKAY;
    assign rresp = `XHCI_RESP_OKAY;
    assign rlast = 1'b1;

    // Write strobes
    assign wr_cmd       = wr_accept && (awaddr == `XHCI_USBCMD_OFS);
    assign eint_clr     = wr_accept && (awaddr == `XHCI_USBSTS_OFS) && wdata[`XHCI_STS_EINT];
    assign portsc_clr   = wr_accept && (awaddr == `XHCI_PORTSC_OFS);
    assign portsc_wdata = wdata;
    assign db_wr        = wr_accept && is_doorbell(awaddr);
    assign db_ep        = awaddr[5:2];
    assign db_value     = wdata[7:0];

    assign rd_ep = araddr[5:2];

    // ---------------------------------------------------------------------------
    // Read multiplexer
    // ---------------------------------------------------------------------------
    always_comb begin
        rd_word = '0;
        if (is_doorbell(araddr)) begin
            rd_word = reg_data_t'(rd_deq);
        end else begin
            case (araddr)
                `XHCI_CAP_OFS:        rd_word = `XHCI_CAP_VALUE;
                `XHCI_HCSPARAMS1_OFS: rd_word = `XHCI_HCSPARAMS1_VALUE;
                `XHCI_USBCMD_OFS:     rd_word[`XHCI_CMD_RUN] = run;
                `XHCI_USBSTS_OFS: begin
                    rd_word[`XHCI_STS_HCH]  = !run && sched_idle;
                    rd_word[`XHCI_STS_EINT] = eint_pending;
                end
                `XHCI_PORTSC_OFS:     rd_word = portsc_value;
                `XHCI_MFINDEX_OFS:    rd_word = reg_data_t'(mfindex);
                default:              rd_word = '0;
            endcase
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            run    <= 1'b0;
        end else begin
            if (wr_accept) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_accept) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            if (wr_cmd) begin
                run <= wdata[`XHCI_CMD_RUN];
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rd_accept) begin
            rdata <= rd_word;
        end
    end

    // A write response only follows a completed aw/w handshake
    a_bvalid_after_write: assert property (@(posedge clk_sys) disable iff (!rst_n_sys)
        $rose(bvalid) |-> $past(awvalid && awready && wvalid && wready));

endmodule

`default_nettype wire

//--- xhci_cases.txt
# op addr value, all hex. W write, R read/compare, D poll doorbell, L LFSR doorbell
# P ports {oc,disc,conn}, I intr {port,event}, M mfindex 0 same 1 larger 2 note, C clocks
R 000 01000040
R 004 10000001
R 044 00000001
R 300 00000000
R 0fc 00000000
M 100 2
C 0 14
M 100 0
W 204 05
W 208 10
R 204 0
R 208 0
W 040 1
R 040 1
D 204 05
D 208 10
R 044 8
I 0 1
W 044 8
R 044 0
I 0 0
C 0 a
I 0 0
L 20c 0
R 044 8
I 0 1
W 044 8
I 0 0
L 210 0
W 044 8
M 100 2
C 0 14
M 100 1
W 040 0
R 044 1
M 100 2
C 0 14
M 100 0
P 0 1
P 0 0
R 080 00020001
I 0 2
P 0 4
P 0 0
R 080 00120001
I 0 2
W 080 00120000
R 080 00000001
I 0 0
P 0 2
P 0 0
R 080 00020000
I 0 2
W 080 00020000
I 0 0

//--- xhci_consts.svh
// xHCI register block constants
// Register offsets, fixed capability values, bit positions and timing
// for the single-port host controller register window

`ifndef XHCI_CONSTS_SVH
`define XHCI_CONSTS_SVH

`define XHCI_NUM_EPS            16

// ---------------------------------------------------------------------------
// Register offsets inside the 4 KB window
// ---------------------------------------------------------------------------
`define XHCI_CAP_OFS            12'h000
`define XHCI_HCSPARAMS1_OFS     12'h004
`define XHCI_USBCMD_OFS         12'h040
`define XHCI_USBSTS_OFS         12'h044
`define XHCI_PORTSC_OFS         12'h080
`define XHCI_MFINDEX_OFS        12'h100
`define XHCI_DB_BASE            12'h200
`define XHCI_DB_MASK            12'hFC0

// Version 1.00, capability length 0x40
`define XHCI_CAP_VALUE          32'h01000040
`define XHCI_HCSPARAMS1_VALUE   32'h10000001

// ---------------------------------------------------------------------------
// Bit positions
// ---------------------------------------------------------------------------
`define XHCI_CMD_RUN            0
`define XHCI_STS_HCH            0
`define XHCI_STS_EINT           3
`define XHCI_PORTSC_CCS         0
`define XHCI_PORTSC_CSC         17
`define XHCI_PORTSC_OCC         20

// Clocks per microframe
`define XHCI_MF_CYCLES          8

`define XHCI_RESP_OKAY          2'd0
`define XHCI_RESP_SLVERR        2'd2

`endif

//--- xhci_controller_top.sv
// xHCI host controller register block, top level
// Connects the AXI register slave, ring scheduler, microframe
// timer and interrupt control on the system clock

`timescale 1ns/1ps
`default_nettype none

module xhci_controller_top (
    input  logic                     clk_sys,
    input  logic                     rst_n_sys,
    input  xhci_reg_pkg::reg_addr_t  awaddr,
    input  logic                     awvalid,
    input  xhci_reg_pkg::reg_data_t  wdata,
    input  logic                     wvalid,
    output logic                     awready,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  xhci_reg_pkg::reg_addr_t  araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output xhci_reg_pkg::reg_data_t  rdata,
    output logic [1:0]               rresp,
    output logic                     rlast,
    output logic                     rvalid,
    input  logic                     rready,
    input  logic                     port_connect,
    input  logic                     port_disconnect,
    input  logic                     port_overcurrent,
    output logic                     event_intr,
    output logic                     port_intr
);
    import xhci_reg_pkg::*;
    import xhci_ring_pkg::*;

    logic      db_wr;
    ep_idx_t   db_ep;
    ring_ptr_t db_value;
    logic      run;
    logic      eint_clr;
    logic      portsc_clr;
    reg_data_t portsc_wdata;
    logic      sched_idle;
    ep_idx_t   rd_ep;
    ring_ptr_t rd_deq;
    mfindex_t  mfindex;
    reg_data_t portsc_value;
    logic      eint_pending;
    logic      ring_done;

    xhci_axi_regs u_axi_regs (
        .clk_sys      (clk_sys),
        .rst_n_sys    (rst_n_sys),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wvalid       (wvalid),
        .wready       (wready),
        .bresp        (bresp),
        .bvalid       (bvalid),
        .bready       (bready),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rlast        (rlast),
        .rvalid       (rvalid),
        .rready       (rready),
        .db_wr        (db_wr),
        .db_ep        (db_ep),
        .db_value     (db_value),
        .run          (run),
        .eint_clr     (eint_clr),
        .portsc_clr   (portsc_clr),
        .portsc_wdata (portsc_wdata),
        .sched_idle   (sched_idle),
        .rd_ep        (rd_ep),
        .rd_deq       (rd_deq),
        .mfindex      (mfindex),
        .portsc_value (portsc_value),
        .eint_pending (eint_pending)
    );

    xhci_ring_sched u_ring_sched (
        .clk_sys    (clk_sys),
        .rst_n_sys  (rst_n_sys),
        .db_wr      (db_wr),
        .db_ep      (db_ep),
        .db_value   (db_value),
        .run        (run),
        .rd_ep      (rd_ep),
        .rd_deq     (rd_deq),
        .sched_idle (sched_idle),
        .ring_done  (ring_done)
    );

    xhci_mfindex_timer u_mfindex_timer (
        .clk_sys   (clk_sys),
        .rst_n_sys (rst_n_sys),
        .run       (run),
        .mfindex   (mfindex)
    );

    xhci_intr_ctrl u_intr_ctrl (
        .clk_sys          (clk_sys),
        .rst_n_sys        (rst_n_sys),
        .port_connect     (port_connect),
        .port_disconnect  (port_disconnect),
        .port_overcurrent (port_overcurrent),
        .ring_done        (ring_done),
        .eint_clr         (eint_clr),
        .portsc_clr       (portsc_clr),
        .portsc_wdata     (portsc_wdata),
        .portsc_value     (portsc_value),
        .eint_pending     (eint_pending),
        .event_intr       (event_intr),
        .port_intr        (port_intr)
    );

endmodule

`default_nettype wire

//--- xhci_intr_ctrl.sv
// xHCI interrupt control
// Port status and change latches, event-pending latch and the
// registered event and port interrupt outputs

`timescale 1ns/1ps
`default_nettype none
`include "xhci_consts.svh"

module xhci_intr_ctrl (
    input  logic                     clk_sys,
    input  logic                     rst_n_sys,
    input  logic                     port_connect,
    input  logic                     port_disconnect,
    input  logic                     port_overcurrent,
    input  logic                     ring_done,
    input  logic                     eint_clr,
    input  logic                     portsc_clr,
    input  xhci_reg_pkg::reg_data_t  portsc_wdata,
    output xhci_reg_pkg::reg_data_t  portsc_value,
    output logic                     eint_pending,
    output logic                     event_intr,
    output logic                     port_intr
);
    import xhci_reg_pkg::*;

    logic ccs;
    logic csc;
    logic occ;

    always_comb begin
        portsc_value = '0;
        portsc_value[`XHCI_PORTSC_CCS] = ccs;
        portsc_value[`XHCI_PORTSC_CSC] = csc;
        portsc_value[`XHCI_PORTSC_OCC] = occ;
    end

    // Clears come first so a new event in the same cycle wins
    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            ccs          <= 1'b0;
            csc          <= 1'b0;
            occ          <= 1'b0;
            eint_pending <= 1'b0;
            event_intr   <= 1'b0;
            port_intr    <= 1'b0;
        end else begin
            if (portsc_clr && portsc_wdata[`XHCI_PORTSC_CSC]) begin
                csc <= 1'b0;
            end
            if (portsc_clr && portsc_wdata[`XHCI_PORTSC_OCC]) begin
                occ <= 1'b0;
            end
            if (port_connect && !ccs) begin
                ccs <= 1'b1;
                csc <= 1'b1;
            end else if (port_disconnect && ccs) begin
                ccs <= 1'b0;
                csc <= 1'b1;
            end
            if (port_overcurrent) begin
                occ <= 1'b1;
            end
            if (eint_clr) begin
                eint_pending <= 1'b0;
            end
            if (ring_done) begin
                eint_pending <= 1'b1;
            end
            event_intr <= eint_pending;
            port_intr  <= csc || occ;
        end
    end

endmodule

`default_nettype wire

//--- xhci_mfindex_timer.sv
// xHCI microframe index timer
// Divides the system clock down to microframes and counts them
// while the controller runs; restarts from zero when run rises

`timescale 1ns/1ps
`default_nettype none
`include "xhci_consts.svh"

module xhci_mfindex_timer (
    input  logic                    clk_sys,
    input  logic                    rst_n_sys,
    input  logic                    run,
    output xhci_reg_pkg::mfindex_t  mfindex
);

    logic [2:0] prescale;
    logic       run_d;

    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            prescale <= '0;
            run_d    <= 1'b0;
            mfindex  <= '0;
        end else begin
            run_d <= run;
            if (run && !run_d) begin
                prescale <= '0;
                mfindex  <= '0;
            end else if (run) begin
                if (prescale == 3'(`XHCI_MF_CYCLES - 1)) begin
                    prescale <= '0;
                    mfindex  <= mfindex + 14'd1;
                end else begin
                    prescale <= prescale + 3'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- xhci_reg_pkg.sv
// xHCI register bus types
// Byte addresses, register words and the microframe index

`default_nettype none

package xhci_reg_pkg;

    // Byte address inside the register window
    typedef logic [11:0] reg_addr_t;

    typedef logic [31:0] reg_data_t;

    // Microframe index, wraps at the top
    typedef logic [13:0] mfindex_t;

endpackage

`default_nettype wire

//--- xhci_ring_pkg.sv
// xHCI endpoint and transfer ring types
// Endpoint numbers, ring slot indices and the scheduler states

`default_nettype none

package xhci_ring_pkg;

    // Endpoint and doorbell number
    typedef logic [3:0] ep_idx_t;

    typedef logic [7:0] ring_ptr_t;

    typedef enum logic [1:0] {
        SCHED_IDLE,
        SCHED_SCAN,
        SCHED_ADVANCE,
        SCHED_POST
    } sched_state_t;

endpackage

`default_nettype wire

//--- xhci_ring_sched.sv
// xHCI transfer ring scheduler
// Keeps an enqueue and a dequeue pointer per endpoint. While the
// controller runs, scans the endpoints round robin and walks each
// doorbelled ring one slot per cycle, pulsing ring_done when drained

`timescale 1ns/1ps
`default_nettype none
`include "xhci_consts.svh"

module xhci_ring_sched (
    input  logic                      clk_sys,
    input  logic                      rst_n_sys,
    input  logic                      db_wr,
    input  xhci_ring_pkg::ep_idx_t    db_ep,
    input  xhci_ring_pkg::ring_ptr_t  db_value,
    input  logic                      run,
    input  xhci_ring_pkg::ep_idx_t    rd_ep,
    output xhci_ring_pkg::ring_ptr_t  rd_deq,
    output logic                      sched_idle,
    output logic                      ring_done
);
    import xhci_ring_pkg::*;

    ring_ptr_t                enq_ptr [`XHCI_NUM_EPS];
    ring_ptr_t                deq_ptr [`XHCI_NUM_EPS];
    logic [`XHCI_NUM_EPS-1:0] pending;
    ring_ptr_t                deq_next;
    ep_idx_t                  cur_ep;
    sched_state_t             state;

    always_comb begin
        for (int i = 0; i < `XHCI_NUM_EPS; i++) begin
            pending[i] = enq_ptr[i] != deq_ptr[i];
        end
    end

    assign deq_next   = deq_ptr[cur_ep] + 8'd1;
    assign rd_deq     = deq_ptr[rd_ep];
    assign sched_idle = state == SCHED_IDLE;
    assign ring_done  = state == SCHED_POST;

    // Doorbell sets the enqueue index
    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            for (int i = 0; i < `XHCI_NUM_EPS; i++) begin
                enq_ptr[i] <= '0;
            end
        end else if (db_wr) begin
            enq_ptr[db_ep] <= db_value;
        end
    end

    // ---------------------------------------------------------------------------
    // Scheduler FSM
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk_sys or negedge rst_n_sys) begin
        if (!rst_n_sys) begin
            state  <= SCHED_IDLE;
            cur_ep <= '0;
            for (int i = 0; i < `XHCI_NUM_EPS; i++) begin
                deq_ptr[i] <= '0;
            end
        end else begin
            case (state)
                SCHED_IDLE: begin
                    if (run && |pending) begin
                        state <= SCHED_SCAN;
                    end
                end
                SCHED_SCAN: begin
                    if (!run || !(|pending)) begin
                        state <= SCHED_IDLE;
                    end else if (pending[cur_ep]) begin
                        state <= SCHED_ADVANCE;
                    end else begin
                        cur_ep <= cur_ep + 4'd1;
                    end
                end
                SCHED_ADVANCE: begin
                    if (!pending[cur_ep]) begin
                        state <= SCHED_POST;
                    end else begin
                        deq_ptr[cur_ep] <= deq_next;
                        if (deq_next == enq_ptr[cur_ep]) begin
                            state <= SCHED_POST;
                        end else if (!run) begin
                            // Stop after this slot
                            state <= SCHED_IDLE;
                        end
                    end
                end
                SCHED_POST: begin
                    cur_ep <= cur_ep + 4'd1;
                    state  <= (run && |pending) ? SCHED_SCAN : SCHED_IDLE;
                end
                default: state <= SCHED_IDLE;
            endcase
        end
    end

    a_done_single: assert property (@(posedge clk_sys) disable iff (!rst_n_sys)
        ring_done |=> !ring_done);

    // Dequeue pointers move only while a ring is being walked
    for (genvar g = 0; g < `XHCI_NUM_EPS; g++) begin : g_deq_chk
        a_deq_in_advance: assert property (@(posedge clk_sys) disable iff (!rst_n_sys)
            !$stable(deq_ptr[g]) |-> $past(state == SCHED_ADVANCE));
    end

endmodule

`default_nettype wire
